// ==== dmem_axil_ram.sv ====
`timescale 1ns/100ps

module dmem_axil_ram (
  input  logic               clk_i,
  input  logic               rst_n_i,

  input  lsu_pkg::axil_aw_t  aw_i,
  input  logic               aw_valid_i,
  output logic               aw_ready_o,
  input  lsu_pkg::axil_w_t   w_i,
  input  logic               w_valid_i,
  output logic               w_ready_o,
  output lsu_pkg::axil_b_t   b_o,
  output logic               b_valid_o,
  input  logic               b_ready_i,

  input  lsu_pkg::axil_ar_t  ar_i,
  input  logic               ar_valid_i,
  output logic               ar_ready_o,
  output lsu_pkg::axil_r_t   r_o,
  output logic               r_valid_o,
  input  logic               r_ready_i
);

  import lsu_pkg::*;

  logic [XLEN-1:0]    mem [DMEM_WORDS];
  logic [DMEM_AW-1:0] aw_idx;
  logic [DMEM_AW-1:0] ar_idx;
  logic               aw_in_range;
  logic               ar_in_range;
  logic               wr_fire;
  logic               rd_fire;
  axil_b_t            b_q;
  axil_r_t            r_q;
  logic               b_valid_q;
  logic               r_valid_q;

  assign aw_idx      = aw_i.addr[DMEM_AW+1:2];
  assign ar_idx      = ar_i.addr[DMEM_AW+1:2];
  assign aw_in_range = (aw_i.addr < XLEN'(DMEM_WORDS * 4));
  assign ar_in_range = (ar_i.addr < XLEN'(DMEM_WORDS * 4));

  // address and data are taken together, one write at a time.
  assign aw_ready_o = aw_valid_i && w_valid_i && !b_valid_q;
  assign w_ready_o  = aw_ready_o;
  assign wr_fire    = aw_ready_o;
  assign ar_ready_o = !r_valid_q;
  assign rd_fire    = ar_valid_i && ar_ready_o;

  assign b_o       = b_q;
  assign b_valid_o = b_valid_q;
  assign r_o       = r_q;
  assign r_valid_o = r_valid_q;

  always_ff @(posedge clk_i) begin
    if (wr_fire && aw_in_range) begin
      for (int i = 0; i < STRB_W; i++) begin
        if (w_i.strb[i]) mem[aw_idx][8*i +: 8] <= w_i.data[8*i +: 8];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      b_valid_q <= 1'b0;
      r_valid_q <= 1'b0;
    end else begin
      if (wr_fire) begin
        b_valid_q <= 1'b1;
      end else if (b_ready_i) begin
        b_valid_q <= 1'b0;
      end
      if (rd_fire) begin
        r_valid_q <= 1'b1;
      end else if (r_ready_i) begin
        r_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_fire) b_q.resp <= aw_in_range ? RESP_OKAY : RESP_SLVERR;
    if (rd_fire) begin
      r_q.data <= ar_in_range ? mem[ar_idx] : '0;    // zero data on error.
      r_q.resp <= ar_in_range ? RESP_OKAY : RESP_SLVERR;
    end
  end

endmodule

// ==== load_extend.sv ====
`timescale 1ns/100ps

module load_extend (
  input  logic [lsu_pkg::XLEN-1:0] rdata_i,
  input  logic [1:0]               addr_i,
  input  lsu_pkg::func3_e          func3_i,

  output logic [lsu_pkg::XLEN-1:0] data_o
);

  import lsu_pkg::*;

  logic [7:0]  byte_sel;
  logic [15:0] half_sel;

  always_comb begin
    case (addr_i)
      2'b00:   byte_sel = rdata_i[7:0];
      2'b01:   byte_sel = rdata_i[15:8];
      2'b10:   byte_sel = rdata_i[23:16];
      2'b11:   byte_sel = rdata_i[31:24];
      default: byte_sel = rdata_i[7:0];
    endcase
  end

  assign half_sel = addr_i[1] ? rdata_i[31:16] : rdata_i[15:0];  // upper or lower half.

  always_comb begin
    case (func3_i)
      F3_B: begin
        data_o = {{(XLEN-8){byte_sel[7]}}, byte_sel};
      end
      F3_BU: begin
        data_o = {{(XLEN-8){1'b0}}, byte_sel};
      end
      F3_H: begin
        data_o = {{(XLEN-16){half_sel[15]}}, half_sel};
      end
      F3_HU: begin
        data_o = {{(XLEN-16){1'b0}}, half_sel};
      end
      F3_W: begin
        data_o = rdata_i;
      end
      default: begin
        data_o = rdata_i;                 // raw word for unknown widths.
      end
    endcase
  end

endmodule

// ==== lsu_axil_master.sv ====
`timescale 1ns/100ps

module lsu_axil_master (
  input  logic                     clk_i,
  input  logic                     rst_n_i,

  input  lsu_pkg::lsu_req_t        req_i,
  input  logic                     req_valid_i,
  output logic                     req_ready_o,
  input  lsu_pkg::axil_w_t         w_aligned_i,
  input  logic [lsu_pkg::XLEN-1:0] load_data_i,
  output lsu_pkg::lsu_rsp_t        rsp_o,
  output logic                     rsp_valid_o,
  output lsu_pkg::func3_e          ld_func3_o,
  output logic [1:0]               ld_addr_o,

  output lsu_pkg::axil_aw_t        aw_o,
  output logic                     aw_valid_o,
  input  logic                     aw_ready_i,
  output lsu_pkg::axil_w_t         w_o,
  output logic                     w_valid_o,
  input  logic                     w_ready_i,
  input  lsu_pkg::axil_b_t         b_i,
  input  logic                     b_valid_i,
  output logic                     b_ready_o,
  output lsu_pkg::axil_ar_t        ar_o,
  output logic                     ar_valid_o,
  input  logic                     ar_ready_i,
  input  lsu_pkg::axil_r_t         r_i,
  input  logic                     r_valid_i,
  output logic                     r_ready_o
);

  import lsu_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WRITE,
    ST_WAIT_B,
    ST_READ,
    ST_WAIT_R,
    ST_RESP
  } state_e;

  state_e   state_q;
  lsu_req_t req_q;
  axil_w_t  w_q;
  lsu_rsp_t rsp_q;
  logic     aw_done_q;
  logic     w_done_q;
  logic     req_fire;
  logic     aw_fire;
  logic     w_fire;

  assign req_ready_o = (state_q == ST_IDLE);
  assign req_fire    = req_valid_i && req_ready_o;

  assign aw_valid_o = (state_q == ST_WRITE) && !aw_done_q;
  assign w_valid_o  = (state_q == ST_WRITE) && !w_done_q;
  assign ar_valid_o = (state_q == ST_READ);
  assign aw_fire    = aw_valid_o && aw_ready_i;
  assign w_fire     = w_valid_o && w_ready_i;

  assign b_ready_o = 1'b1;                // responses are never stalled.
  assign r_ready_o = 1'b1;

  assign aw_o.addr = req_q.addr;
  assign ar_o.addr = req_q.addr;
  assign w_o       = w_q;

  assign ld_func3_o  = req_q.func3;
  assign ld_addr_o   = req_q.addr[1:0];
  assign rsp_o       = rsp_q;
  assign rsp_valid_o = (state_q == ST_RESP);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q   <= ST_IDLE;
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (req_fire) begin
            aw_done_q <= 1'b0;
            w_done_q  <= 1'b0;
            state_q   <= (req_i.op == LSU_STORE) ? ST_WRITE : ST_READ;
          end
        end
        ST_WRITE: begin
          if (aw_fire) aw_done_q <= 1'b1;
          if (w_fire) w_done_q <= 1'b1;
          if ((aw_done_q || aw_fire) && (w_done_q || w_fire)) begin
            state_q <= ST_WAIT_B;
          end
        end
        ST_WAIT_B: begin
          if (b_valid_i) state_q <= ST_RESP;
        end
        ST_READ: begin
          if (ar_ready_i) state_q <= ST_WAIT_R;
        end
        ST_WAIT_R: begin
          if (r_valid_i) state_q <= ST_RESP;
        end
        ST_RESP: begin
          state_q <= ST_IDLE;
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      req_q <= req_i;
      w_q   <= w_aligned_i;               // lanes computed from the presented request.
    end
    if ((state_q == ST_WAIT_B) && b_valid_i) begin
      rsp_q.rdata <= '0;
      rsp_q.err   <= (b_i.resp == RESP_SLVERR);
    end
    if ((state_q == ST_WAIT_R) && r_valid_i) begin
      rsp_q.rdata <= (r_i.resp == RESP_SLVERR) ? '0 : load_data_i;
      rsp_q.err   <= (r_i.resp == RESP_SLVERR);
    end
  end

endmodule

// ==== lsu_pkg.sv ====
package lsu_pkg;

  localparam int XLEN       = 32;
  localparam int STRB_W     = XLEN / 8;
  localparam int DMEM_WORDS = 256;
  localparam int DMEM_AW    = 8;          // word index width, log2 of DMEM_WORDS.

  typedef enum logic {
    LSU_LOAD  = 1'b0,
    LSU_STORE = 1'b1
  } lsu_op_e;

  // rv32 load/store width field.
  typedef enum logic [2:0] {
    F3_B  = 3'b000,
    F3_H  = 3'b001,
    F3_W  = 3'b010,
    F3_BU = 3'b100,
    F3_HU = 3'b101
  } func3_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axil_resp_e;

  typedef struct packed {
    lsu_op_e         op;
    func3_e          func3;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] wdata;
  } lsu_req_t;

  typedef struct packed {
    logic [XLEN-1:0] rdata;
    logic            err;
  } lsu_rsp_t;

  typedef struct packed {
    logic [XLEN-1:0] addr;
  } axil_aw_t;

  typedef struct packed {
    logic [XLEN-1:0] addr;
  } axil_ar_t;

  typedef struct packed {
    logic [XLEN-1:0]   data;
    logic [STRB_W-1:0] strb;             // bit 0 is byte lane 0.
  } axil_w_t;

  typedef struct packed {
    axil_resp_e resp;
  } axil_b_t;

  typedef struct packed {
    logic [XLEN-1:0] data;
    axil_resp_e      resp;
  } axil_r_t;

endpackage

// ==== lsu_top.f ====
lsu_pkg.sv
store_align.sv
load_extend.sv
lsu_axil_master.sv
dmem_axil_ram.sv
lsu_top.sv
tb_lsu_top.sv

// ==== lsu_top.sv ====
`timescale 1ns/100ps

module lsu_top (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  lsu_pkg::lsu_req_t req_i,
  input  logic              req_valid_i,
  output logic              req_ready_o,
  output lsu_pkg::lsu_rsp_t rsp_o,
  output logic              rsp_valid_o
);

  import lsu_pkg::*;

  axil_w_t         w_aligned;
  logic [XLEN-1:0] load_data;
  func3_e          ld_func3;
  logic [1:0]      ld_addr;

  axil_aw_t        aw;
  logic            aw_valid;
  logic            aw_ready;
  axil_w_t         w;
  logic            w_valid;
  logic            w_ready;
  axil_b_t         b;
  logic            b_valid;
  logic            b_ready;
  axil_ar_t        ar;
  logic            ar_valid;
  logic            ar_ready;
  axil_r_t         r;
  logic            r_valid;
  logic            r_ready;

  store_align u_store_align (
    .addr_i  (req_i.addr[1:0]),
    .wdata_i (req_i.wdata),
    .func3_i (req_i.func3),
    .w_o     (w_aligned)
  );

  load_extend u_load_extend (
    .rdata_i (r.data),                  // extended from the live R beat.
    .addr_i  (ld_addr),
    .func3_i (ld_func3),
    .data_o  (load_data)
  );

  lsu_axil_master u_master (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_i       (req_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .w_aligned_i (w_aligned),
    .load_data_i (load_data),
    .rsp_o       (rsp_o),
    .rsp_valid_o (rsp_valid_o),
    .ld_func3_o  (ld_func3),
    .ld_addr_o   (ld_addr),
    .aw_o        (aw),
    .aw_valid_o  (aw_valid),
    .aw_ready_i  (aw_ready),
    .w_o         (w),
    .w_valid_o   (w_valid),
    .w_ready_i   (w_ready),
    .b_i         (b),
    .b_valid_i   (b_valid),
    .b_ready_o   (b_ready),
    .ar_o        (ar),
    .ar_valid_o  (ar_valid),
    .ar_ready_i  (ar_ready),
    .r_i         (r),
    .r_valid_i   (r_valid),
    .r_ready_o   (r_ready)
  );

  dmem_axil_ram u_dmem (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .aw_i       (aw),
    .aw_valid_i (aw_valid),
    .aw_ready_o (aw_ready),
    .w_i        (w),
    .w_valid_i  (w_valid),
    .w_ready_o  (w_ready),
    .b_o        (b),
    .b_valid_o  (b_valid),
    .b_ready_i  (b_ready),
    .ar_i       (ar),
    .ar_valid_i (ar_valid),
    .ar_ready_o (ar_ready),
    .r_o        (r),
    .r_valid_o  (r_valid),
    .r_ready_i  (r_ready)
  );

endmodule

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f lsu_top.f --top-module tb_lsu_top -o tb_lsu_top
out=$(./obj_dir/tb_lsu_top 2>&1) || true
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qF '*** PASSED ***'; then
  exit 0
fi
exit 1

// ==== store_align.sv ====
`timescale 1ns/100ps

module store_align (
  input  logic [1:0]               addr_i,
  input  logic [lsu_pkg::XLEN-1:0] wdata_i,
  input  lsu_pkg::func3_e          func3_i,

  output lsu_pkg::axil_w_t         w_o
);

  import lsu_pkg::*;

  always_comb begin
    w_o.data = wdata_i;
    w_o.strb = '0;

    case (func3_i)
      F3_W: begin
        w_o.data = wdata_i;
        w_o.strb = 4'b1111;
      end
      F3_H: begin
        case (addr_i[1])                  // addr_i[0] is ignored for halfwords.
          1'b0: begin
            w_o.data = {16'b0, wdata_i[15:0]};
            w_o.strb = 4'b0011;
          end
          1'b1: begin
            w_o.data = {wdata_i[15:0], 16'b0};
            w_o.strb = 4'b1100;
          end
          default: begin
            w_o.data = wdata_i;
            w_o.strb = '0;
          end
        endcase
      end
      F3_B: begin
        case (addr_i)
          2'b00: begin
            w_o.data = {24'b0, wdata_i[7:0]};
            w_o.strb = 4'b0001;
          end
          2'b01: begin
            w_o.data = {16'b0, wdata_i[7:0], 8'b0};
            w_o.strb = 4'b0010;
          end
          2'b10: begin
            w_o.data = {8'b0, wdata_i[7:0], 16'b0};
            w_o.strb = 4'b0100;
          end
          2'b11: begin
            w_o.data = {wdata_i[7:0], 24'b0};
            w_o.strb = 4'b1000;
          end
          default: begin
            w_o.data = wdata_i;
            w_o.strb = '0;
          end
        endcase
      end
      default: begin
        // unsupported width, the write leaves memory alone.
        w_o.data = wdata_i;
        w_o.strb = '0;
      end
    endcase
  end

endmodule

// ==== tb_lsu_top.sv ====
`timescale 1ns/100ps

module tb_lsu_top;

  import lsu_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int DRIVE_DLY  = 10;
  localparam int WAIT_LIMIT = 50;            // cycles per wait loop.
  localparam int RAM_BYTES  = DMEM_WORDS * 4;

  typedef struct packed {
    lsu_op_e         op;
    logic [2:0]      func3;                  // raw code, illegal ones allowed.
    logic [XLEN-1:0] addr;
    logic            use_lfsr;
    logic [XLEN-1:0] wdata;
    logic            exp_err;
  } entry_t;

  logic        clk;
  logic        rst_n;
  lsu_req_t    req;
  logic        req_valid;
  logic        req_ready;
  lsu_rsp_t    rsp;
  logic        rsp_valid;
  entry_t      stim_q[$];
  logic [7:0]  shadow_mem [RAM_BYTES];
  logic [31:0] lfsr_q;

  lsu_top dut_i (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .req_i       (req),
    .req_valid_i (req_valid),
    .req_ready_o (req_ready),
    .rsp_o       (rsp),
    .rsp_valid_o (rsp_valid)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hB4BC_D35C) : (s >> 1);
  endfunction

  // one lfsr step per bit taken.
  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits   = {bits[30:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
    return bits;
  endfunction

  function automatic logic [XLEN-1:0] predict_load(input logic [2:0] func3,
                                                   input logic [XLEN-1:0] addr);
    logic [XLEN-1:0] word;
    logic [XLEN-1:0] result;
    logic [7:0]      lane_byte;
    logic [15:0]     half;
    int              base;
    if (addr >= XLEN'(RAM_BYTES)) return '0;
    base      = int'(addr[9:2]) * 4;
    word      = {shadow_mem[base+3], shadow_mem[base+2], shadow_mem[base+1], shadow_mem[base]};
    lane_byte = word[8*addr[1:0] +: 8];
    half      = addr[1] ? word[31:16] : word[15:0];
    case (func3)
      F3_B:    result = {{24{lane_byte[7]}}, lane_byte};
      F3_BU:   result = {24'b0, lane_byte};
      F3_H:    result = {{16{half[15]}}, half};
      F3_HU:   result = {16'b0, half};
      default: result = word;               // word loads and unknown codes.
    endcase
    return result;
  endfunction

  task automatic shadow_store(input logic [2:0] func3, input logic [XLEN-1:0] addr,
                              input logic [XLEN-1:0] wdata);
    int base;
    base = int'(addr[9:2]) * 4;
    case (func3)
      F3_W: begin
        for (int k = 0; k < 4; k++) shadow_mem[base+k] = wdata[8*k +: 8];
      end
      F3_H: begin
        shadow_mem[base + 2*int'(addr[1])]     = wdata[7:0];
        shadow_mem[base + 2*int'(addr[1]) + 1] = wdata[15:8];
      end
      F3_B: begin
        shadow_mem[base + int'(addr[1:0])] = wdata[7:0];
      end
      default: begin
        // no lane is written.
      end
    endcase
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("FAILED at %0t ns: %s = %h, expected %h", $time, name, actual, expected);
      $display("*** FAILED ***");
      $fatal(1);
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout at %0t ns: %s did not rise within %0d cycles", $time, what, WAIT_LIMIT);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  task automatic add_entry(input lsu_op_e op, input logic [2:0] func3,
                           input logic [XLEN-1:0] addr, input logic use_lfsr,
                           input logic [XLEN-1:0] wdata, input logic exp_err);
    entry_t e;
    e.op       = op;
    e.func3    = func3;
    e.addr     = addr;
    e.use_lfsr = use_lfsr;
    e.wdata    = wdata;
    e.exp_err  = exp_err;
    stim_q.push_back(e);
  endtask

  task automatic fill_table();
    // full words.
    add_entry(LSU_STORE, F3_W, 32'h000, 1'b1, 32'h0, 1'b0);
    add_entry(LSU_LOAD,  F3_W, 32'h000, 1'b0, 32'h0, 1'b0);
    add_entry(LSU_STORE, F3_W, 32'h004, 1'b1, 32'h0, 1'b0);
    add_entry(LSU_LOAD,  F3_W, 32'h004, 1'b0, 32'h0, 1'b0);
    // byte lanes.
    add_entry(LSU_STORE, F3_W, 32'h010, 1'b0, 32'hAAAA_AAAA, 1'b0);
    for (int k = 0; k < 4; k++) begin
      add_entry(LSU_STORE, F3_B, 32'h010 + 32'(k), 1'b1, 32'h0, 1'b0);
      add_entry(LSU_LOAD,  F3_W, 32'h010, 1'b0, 32'h0, 1'b0);
    end
    // halfwords, fixed then random.
    add_entry(LSU_STORE, F3_W, 32'h020, 1'b0, 32'h0, 1'b0);
    add_entry(LSU_STORE, F3_H, 32'h020, 1'b0, 32'h1234_8123, 1'b0);
    add_entry(LSU_STORE, F3_H, 32'h022, 1'b0, 32'hFFFF_4567, 1'b0);
    add_entry(LSU_LOAD,  F3_W, 32'h020, 1'b0, 32'h0, 1'b0);
    for (int r = 0; r < 2; r++) begin
      for (int h = 0; h < 2; h++) begin
        if (r == 1) add_entry(LSU_STORE, F3_H, 32'h020 + 32'(2*h), 1'b1, 32'h0, 1'b0);
        add_entry(LSU_LOAD, F3_H,  32'h020 + 32'(2*h), 1'b0, 32'h0, 1'b0);
        add_entry(LSU_LOAD, F3_HU, 32'h020 + 32'(2*h), 1'b0, 32'h0, 1'b0);
      end
    end
    // bytes of both signs.
    add_entry(LSU_STORE, F3_W, 32'h030, 1'b0, 32'h7F80_01FE, 1'b0);
    for (int k = 0; k < 4; k++) begin
      add_entry(LSU_LOAD, F3_B,  32'h030 + 32'(k), 1'b0, 32'h0, 1'b0);
      add_entry(LSU_LOAD, F3_BU, 32'h030 + 32'(k), 1'b0, 32'h0, 1'b0);
    end
    // out of range.
    add_entry(LSU_STORE, F3_W, 32'h400, 1'b1, 32'h0, 1'b1);
    add_entry(LSU_LOAD,  F3_W, 32'h400, 1'b0, 32'h0, 1'b1);
    add_entry(LSU_STORE, F3_B, 32'h7FD, 1'b1, 32'h0, 1'b1);
    add_entry(LSU_LOAD,  F3_H, 32'hFFFF_FFFE, 1'b0, 32'h0, 1'b1);
    add_entry(LSU_LOAD,  F3_W, 32'h000, 1'b0, 32'h0, 1'b0);
    // illegal widths.
    add_entry(LSU_STORE, F3_W,   32'h040, 1'b1, 32'h0, 1'b0);
    add_entry(LSU_STORE, 3'b011, 32'h040, 1'b1, 32'h0, 1'b0);
    add_entry(LSU_STORE, 3'b111, 32'h041, 1'b1, 32'h0, 1'b0);
    add_entry(LSU_STORE, 3'b110, 32'h042, 1'b1, 32'h0, 1'b0);
    add_entry(LSU_LOAD,  F3_W,   32'h040, 1'b0, 32'h0, 1'b0);
    add_entry(LSU_LOAD,  3'b011, 32'h040, 1'b0, 32'h0, 1'b0);
  endtask

  task automatic run_entry(input entry_t e);
    logic [XLEN-1:0] wdata;
    logic [XLEN-1:0] exp_rdata;
    int              cycles;
    wdata  = e.use_lfsr ? random_bits(32) : e.wdata;
    cycles = 0;
    while (!req_ready) begin
      @(posedge clk);
      #DRIVE_DLY;
      cycles++;
      if (cycles > WAIT_LIMIT) report_timeout("req_ready_o");
    end
    req.op    = e.op;
    req.func3 = func3_e'(e.func3);
    req.addr  = e.addr;
    req.wdata = wdata;
    req_valid = 1'b1;
    @(posedge clk);                          // handshake edge.
    #DRIVE_DLY;
    req_valid = 1'b0;
    cycles    = 0;
    while (!rsp_valid) begin
      @(posedge clk);
      #DRIVE_DLY;
      cycles++;
      if (cycles > WAIT_LIMIT) report_timeout("rsp_valid_o");
    end
    check_value("rsp_o.err", 32'(rsp.err), 32'(e.exp_err));
    if (e.op == LSU_STORE) begin
      check_value("rsp_o.rdata", rsp.rdata, 32'h0);
      if (!e.exp_err) shadow_store(e.func3, e.addr, wdata);
    end else begin
      exp_rdata = predict_load(e.func3, e.addr);
      check_value("rsp_o.rdata", rsp.rdata, exp_rdata);
    end
    @(posedge clk);
    #DRIVE_DLY;
    check_value("rsp_valid_o", 32'(rsp_valid), 32'h0);  // single-cycle pulse.
  endtask

  initial begin
    rst_n     = 1'b0;
    req_valid = 1'b0;
    req       = '0;
    lfsr_q    = 32'd32491;
    for (int i = 0; i < RAM_BYTES; i++) shadow_mem[i] = 8'h00;
    fill_table();
    repeat (3) @(posedge clk);
    #DRIVE_DLY;
    rst_n = 1'b1;
    check_value("req_ready_o", 32'(req_ready), 32'h1);
    check_value("rsp_valid_o", 32'(rsp_valid), 32'h0);
    foreach (stim_q[i]) begin
      run_entry(stim_q[i]);
    end
    $display("*** PASSED ***");
    $finish;
  end

endmodule
